// ==== source/mem_system_pkg.sv ====
`default_nettype none

package mem_system_pkg;

	// Core word and address widths
	localparam int ADDR_W = 16;
	localparam int WORD_W = 16;

	// Address split is tag[15:8], index[7:3], offset[2:0]
	localparam int TAG_W = 8;
	localparam int INDEX_W = 5;
	localparam int OFFSET_W = 3;
	localparam int LINES = 1 << INDEX_W;

	localparam int WORDS_PER_LINE = 4;
	localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);       // Word within a line

	// Main memory geometry
	localparam int BANKS = 4;
	localparam int BANK_W = $clog2(BANKS);                    // Bank select is addr[2:1]
	localparam int MEM_READ_LATENCY = 2;                      // Strobe to data, in cycles
	localparam int MEM_WORDS = 32768;
	localparam int ROWS = MEM_WORDS / BANKS;
	localparam int ROW_W = $clog2(ROWS);

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [1:0] way_mask_t;                           // One bit per way

endpackage

`default_nettype wire

// ==== source/cache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_way (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     enable,
	input  wire logic                     comp,
	input  wire logic                     write,
	input  wire mem_system_pkg::index_t   index,
	input  wire mem_system_pkg::offset_t  offset,
	input  wire mem_system_pkg::tag_t     tag_in,
	input  wire mem_system_pkg::word_t    data_in,
	output logic                          hit,
	output logic                          valid,
	output logic                          dirty,
	output mem_system_pkg::tag_t          tag_out,
	output mem_system_pkg::word_t         data_out
);

	import mem_system_pkg::*;

	tag_t tag_mem [LINES];
	word_t data_mem [LINES*WORDS_PER_LINE];
	logic [LINES-1:0] valid_mem;
	logic [LINES-1:0] dirty_mem;

	logic [INDEX_W+WORD_SEL_W-1:0] word_addr;
	logic cmp_wr;
	logic fill_wr;

	// Line select plus word within the line, byte bit dropped
	assign word_addr = {index, offset[WORD_SEL_W:1]};

	// Lookups are combinational on the current index
	assign tag_out = tag_mem[index];
	assign valid = valid_mem[index];
	assign dirty = dirty_mem[index];
	assign data_out = data_mem[word_addr];
	assign hit = (tag_mem[index] == tag_in);

	assign cmp_wr = enable & write & comp & hit & valid;   // Core write into a resident line
	assign fill_wr = enable & write & ~comp;              // Line fill from memory

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_mem <= '0;
		end else if (fill_wr) begin
			valid_mem[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (cmp_wr) begin
			data_mem[word_addr] <= data_in;
			dirty_mem[index] <= 1'b1;                     // Line now differs from memory
		end else if (fill_wr) begin
			data_mem[word_addr] <= data_in;
			tag_mem[index] <= tag_in;
			dirty_mem[index] <= 1'b0;
		end
	end

	// The controller must only issue compare writes to the way that holds the line
	a_cmp_wr_hits: assert property (
		@(posedge clk) disable iff (!rst_n)
		(enable && comp && write) |-> (hit && valid)
	) else $error("cache_way: compare write without a valid hit");

endmodule

`default_nettype wire

// ==== source/cache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_controller (
	input  wire logic                        clk,
	input  wire logic                        rst_n,
	input  wire mem_system_pkg::addr_t       addr_in,
	input  wire mem_system_pkg::word_t       data_in,
	input  wire logic                        rd_in,
	input  wire logic                        wr_in,
	input  wire mem_system_pkg::way_mask_t   way_hit,
	input  wire mem_system_pkg::way_mask_t   way_valid,
	input  wire mem_system_pkg::way_mask_t   way_dirty,
	output mem_system_pkg::addr_t            addr_out,
	output mem_system_pkg::word_t            data_out,
	output mem_system_pkg::offset_t          cache_offset,
	output mem_system_pkg::way_mask_t        cache_enable,
	output logic                             comp,
	output logic                             write,
	output mem_system_pkg::offset_t          mem_offset,
	output logic                             mem_rd,
	output logic                             mem_wr,
	output logic                             data_src,
	output logic                             tag_src,
	output logic                             done,
	output logic                             stall,
	output logic                             cache_hit,
	output logic                             err
);

	import mem_system_pkg::*;

	typedef enum logic [3:0] {
		IDLE,
		COMPARE,
		VICTIM,
		WB0,
		WB1,
		WB2,
		WB3,
		FETCH0,
		FETCH1,
		FETCH2_FILL0,
		FETCH3_FILL1,
		FILL2,
		FILL3,
		DONE,
		MISALIGN
	} ctrl_state_t;

	ctrl_state_t state;
	ctrl_state_t next_state;

	addr_t addr_q;
	word_t data_q;
	logic req_wr;                 // Registered access kind, 1 for write
	logic victim_bit;
	way_mask_t victim_q;          // Way being evicted and refilled
	way_mask_t victim_pick;
	way_mask_t hit_mask;
	logic any_hit;
	logic accept;

	assign addr_out = addr_q;
	assign data_out = data_q;

	assign hit_mask = way_hit & way_valid;
	assign any_hit = |hit_mask;

	// Prefer an empty way, otherwise follow the toggling victim bit
	assign victim_pick = !way_valid[0] ? 2'b01 :
	                     !way_valid[1] ? 2'b10 :
	                     victim_bit ? 2'b10 : 2'b01;

	always_comb begin
		next_state = state;
		cache_offset = addr_q[OFFSET_W-1:0];
		cache_enable = '0;
		comp = 1'b0;
		write = 1'b0;
		mem_offset = '0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		data_src = 1'b0;
		tag_src = 1'b0;
		done = 1'b0;
		stall = 1'b1;
		cache_hit = 1'b0;
		err = 1'b0;
		accept = 1'b0;

		case (state)
			IDLE: begin
				stall = 1'b0;
			end
			COMPARE: begin
				comp = 1'b1;
				cache_enable = any_hit ? hit_mask : 2'b11;
				write = any_hit & req_wr;                       // Write only into the hitting way
				done = any_hit;
				cache_hit = any_hit;
				stall = ~any_hit;
				next_state = any_hit ? IDLE : VICTIM;
			end
			VICTIM: begin
				next_state = |(victim_pick & way_valid & way_dirty) ? WB0 : FETCH0;
			end
			WB0, WB1, WB2, WB3: begin
				cache_enable = victim_q;
				tag_src = 1'b1;                                 // Address the victim's line
				mem_wr = 1'b1;
				case (state)
					WB0: begin
						cache_offset = 3'b000;
						next_state = WB1;
					end
					WB1: begin
						cache_offset = 3'b010;
						next_state = WB2;
					end
					WB2: begin
						cache_offset = 3'b100;
						next_state = WB3;
					end
					default: begin
						cache_offset = 3'b110;
						next_state = FETCH0;
					end
				endcase
				mem_offset = cache_offset;
			end
			FETCH0: begin
				mem_rd = 1'b1;
				mem_offset = 3'b000;
				next_state = FETCH1;
			end
			FETCH1: begin
				mem_rd = 1'b1;
				mem_offset = 3'b010;
				next_state = FETCH2_FILL0;
			end
			FETCH2_FILL0: begin
				mem_rd = 1'b1;
				mem_offset = 3'b100;
				cache_enable = victim_q;
				write = 1'b1;
				data_src = 1'b1;
				cache_offset = 3'b000;                          // Word 0 read two cycles ago
				next_state = FETCH3_FILL1;
			end
			FETCH3_FILL1: begin
				mem_rd = 1'b1;
				mem_offset = 3'b110;
				cache_enable = victim_q;
				write = 1'b1;
				data_src = 1'b1;
				cache_offset = 3'b010;
				next_state = FILL2;
			end
			FILL2: begin
				cache_enable = victim_q;
				write = 1'b1;
				data_src = 1'b1;
				cache_offset = 3'b100;
				next_state = FILL3;
			end
			FILL3: begin
				cache_enable = victim_q;
				write = 1'b1;
				data_src = 1'b1;
				cache_offset = 3'b110;
				next_state = DONE;
			end
			DONE: begin
				cache_enable = victim_q;
				comp = 1'b1;                                    // Replay the access on the new line
				write = req_wr;
				done = 1'b1;
				stall = 1'b0;
				next_state = IDLE;
			end
			MISALIGN: begin
				err = 1'b1;
				done = 1'b1;
				stall = 1'b0;
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase

		// New request can be taken whenever stall is low
		if ((rd_in || wr_in) && !stall) begin
			accept = 1'b1;
			next_state = addr_in[0] ? MISALIGN : COMPARE;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			victim_bit <= 1'b0;
			victim_q <= '0;
		end else begin
			state <= next_state;
			if (state == COMPARE) begin
				victim_bit <= ~victim_bit;
			end
			if (state == VICTIM) begin
				victim_q <= victim_pick;                        // Held for write-back and fill
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= addr_in;
			data_q <= data_in;
			req_wr <= wr_in;
		end
	end

	a_one_way_outside_compare: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(state inside {IDLE, COMPARE}) |-> (cache_enable != 2'b11)
	) else $error("cache_controller: both ways enabled during a miss sequence");

	a_done_not_stalled: assert property (
		@(posedge clk) disable iff (!rst_n)
		done |-> !stall
	) else $error("cache_controller: done raised while stalled");

endmodule

`default_nettype wire

// ==== source/banked_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module banked_memory (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    rd,
	input  wire logic                    wr,
	input  wire mem_system_pkg::addr_t   addr,
	input  wire mem_system_pkg::word_t   wr_data,
	output mem_system_pkg::word_t        rd_data
);

	import mem_system_pkg::*;

	// Word-interleaved storage, consecutive words land in consecutive banks
	word_t bank_mem [BANKS][ROWS] = '{default: '0};

	logic [BANK_W-1:0] bank_sel;
	logic [ROW_W-1:0] row_sel;

	// Read request pipeline, the last stage indexes the banks
	logic [MEM_READ_LATENCY-2:0] pipe_vld;
	logic [BANK_W-1:0] pipe_bank [MEM_READ_LATENCY-1];
	logic [ROW_W-1:0] pipe_row [MEM_READ_LATENCY-1];

	assign bank_sel = addr[BANK_W:1];
	assign row_sel = addr[ADDR_W-1:BANK_W+1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pipe_vld <= '0;
		end else begin
			pipe_vld[0] <= rd;
			for (int i = 1; i < MEM_READ_LATENCY - 1; i++) begin
				pipe_vld[i] <= pipe_vld[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		pipe_bank[0] <= bank_sel;
		pipe_row[0] <= row_sel;
		for (int i = 1; i < MEM_READ_LATENCY - 1; i++) begin
			pipe_bank[i] <= pipe_bank[i-1];
			pipe_row[i] <= pipe_row[i-1];
		end

		if (wr) begin
			bank_mem[bank_sel][row_sel] <= wr_data;    // Lands on the sampling edge
		end

		if (pipe_vld[MEM_READ_LATENCY-2]) begin
			rd_data <= bank_mem[pipe_bank[MEM_READ_LATENCY-2]][pipe_row[MEM_READ_LATENCY-2]];
		end
	end

	a_no_rd_wr: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(rd && wr)
	) else $error("banked_memory: read and write strobes together");

endmodule

`default_nettype wire

// ==== source/mem_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_system (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire mem_system_pkg::addr_t   addr,
	input  wire mem_system_pkg::word_t   data_in,
	input  wire logic                    rd,
	input  wire logic                    wr,
	output mem_system_pkg::word_t        data_out,
	output logic                         done,
	output logic                         stall,
	output logic                         cache_hit,
	output logic                         err
);

	import mem_system_pkg::*;

	addr_t req_addr;
	word_t req_data;
	offset_t cache_offset;
	offset_t mem_offset;
	way_mask_t cache_enable;
	way_mask_t way_hit;
	way_mask_t way_valid;
	way_mask_t way_dirty;
	logic comp;
	logic write;
	logic mem_rd;
	logic mem_wr;
	logic data_src;
	logic tag_src;

	tag_t req_tag;
	index_t req_index;
	tag_t way0_tag;
	tag_t way1_tag;
	word_t way0_data;
	word_t way1_data;
	word_t way_wr_data;
	word_t way_sel_data;
	tag_t mem_tag;
	addr_t mem_addr;
	word_t mem_rd_data;
	logic way_sel;

	assign req_tag = req_addr[ADDR_W-1:ADDR_W-TAG_W];
	assign req_index = req_addr[INDEX_W+OFFSET_W-1:OFFSET_W];

	// Way 1 when it hits, or when it alone is enabled for eviction or refill
	assign way_sel = (way_hit[1] & way_valid[1]) | (cache_enable == 2'b10);
	assign way_sel_data = way_sel ? way1_data : way0_data;

	assign way_wr_data = data_src ? mem_rd_data : req_data;      // Fill data or core data
	assign mem_tag = tag_src ? (way_sel ? way1_tag : way0_tag) : req_tag;
	assign mem_addr = {mem_tag, req_index, mem_offset};
	assign data_out = way_sel_data;

	cache_controller ctrl (
		.clk(clk), .rst_n(rst_n), .addr_in(addr), .data_in(data_in), .rd_in(rd), .wr_in(wr),
		.way_hit(way_hit), .way_valid(way_valid), .way_dirty(way_dirty),
		.addr_out(req_addr), .data_out(req_data), .cache_offset(cache_offset),
		.cache_enable(cache_enable), .comp(comp), .write(write), .mem_offset(mem_offset),
		.mem_rd(mem_rd), .mem_wr(mem_wr), .data_src(data_src), .tag_src(tag_src),
		.done(done), .stall(stall), .cache_hit(cache_hit), .err(err)
	);

	cache_way way0 (
		.clk(clk), .rst_n(rst_n), .enable(cache_enable[0]), .comp(comp), .write(write),
		.index(req_index), .offset(cache_offset), .tag_in(req_tag), .data_in(way_wr_data),
		.hit(way_hit[0]), .valid(way_valid[0]), .dirty(way_dirty[0]),
		.tag_out(way0_tag), .data_out(way0_data)
	);

	cache_way way1 (
		.clk(clk), .rst_n(rst_n), .enable(cache_enable[1]), .comp(comp), .write(write),
		.index(req_index), .offset(cache_offset), .tag_in(req_tag), .data_in(way_wr_data),
		.hit(way_hit[1]), .valid(way_valid[1]), .dirty(way_dirty[1]),
		.tag_out(way1_tag), .data_out(way1_data)
	);

	banked_memory mem (
		.clk(clk), .rst_n(rst_n), .rd(mem_rd), .wr(mem_wr), .addr(mem_addr),
		.wr_data(way_sel_data), .rd_data(mem_rd_data)            // Write-back from victim way
	);

endmodule

`default_nettype wire

// ==== bench/mem_system_tests.svh ====
`ifndef MEM_SYSTEM_TESTS_SVH
`define MEM_SYSTEM_TESTS_SVH

task automatic test_cold_read();
	int cyc;
	logic hit;
	access_check(1'b0, 16'h1234, '0, 1'b0, cyc, hit);
	check_value(cyc, 9, "cold read miss latency");
	check_value(hit, 1'b0, "cold read cache_hit");
	access_check(1'b0, 16'h1234, '0, 1'b0, cyc, hit);     // Same word again
	check_value(cyc, 1, "repeated read latency");
	check_value(hit, 1'b1, "repeated read cache_hit");
endtask

task automatic test_line_write();
	logic [31:0] r;
	int cyc;
	logic hit;
	take_bits(16, r);
	access_check(1'b1, 16'h2a44, r[15:0], 1'b0, cyc, hit);
	for (int w = 0; w < 4; w++) begin
		access_check(1'b0, 16'h2a40 + addr_t'(2 * w), '0, 1'b0, cyc, hit);
		check_value(hit, 1'b1, "read within the written line");
	end
endtask

// Three tags at index 17 force evictions from a two-way set
task automatic test_conflict();
	logic [31:0] r;
	addr_t a;
	int cyc;
	logic hit;
	for (int i = 0; i < 3; i++) begin
		take_bits(16, r);
		a = {tag_t'(8'h51 + 8'h11 * i), 5'd17, 3'b100};
		access_check(1'b1, a, r[15:0], 1'b0, cyc, hit);
	end
	for (int i = 0; i < 3; i++) begin
		a = {tag_t'(8'h51 + 8'h11 * i), 5'd17, 3'b100};
		access_check(1'b0, a, '0, 1'b0, cyc, hit);
	end
endtask

task automatic test_random_traffic();
	logic [31:0] kind;
	logic [31:0] t;
	logic [31:0] i;
	logic [31:0] w;
	logic [31:0] d;
	addr_t a;
	int cyc;
	logic hit;
	for (int n = 0; n < 200; n++) begin
		take_bits(1, kind);
		take_bits(2, t);
		take_bits(1, i);
		take_bits(2, w);
		take_bits(16, d);
		a = {6'd0, t[1:0], 4'd0, i[0], w[1:0], 1'b0};   // Four tags over two sets
		access_check(kind[0], a, d[15:0], 1'b0, cyc, hit);
	end
endtask

task automatic test_misaligned();
	int cyc;
	logic hit;
	access_check(1'b1, 16'h2a43, 16'hdead, 1'b0, cyc, hit);
	check_value(cyc, 1, "misaligned write latency");
	access_check(1'b0, 16'h1235, '0, 1'b0, cyc, hit);
	check_value(cyc, 1, "misaligned read latency");
	access_check(1'b0, 16'h2a42, '0, 1'b0, cyc, hit);     // Neighbor word untouched
endtask

task automatic test_stall_ignored();
	logic [31:0] r;
	int cyc;
	logic hit;
	take_bits(16, r);
	access_check(1'b1, 16'hc018, r[15:0], 1'b1, cyc, hit);
	access_check(1'b0, 16'hc118, '0, 1'b1, cyc, hit);
	access_check(1'b0, 16'hc018, '0, 1'b1, cyc, hit);
endtask

`endif

// ==== bench/mem_system_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_system_tb;

	import mem_system_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_REQUESTS = 230;          // Upper bound over all tests
	localparam int CYCLES_PER_REQUEST = 20;
	localparam int WAIT_LIMIT = 20;             // Longest miss completes at cycle 13

	logic clk;
	logic rst_n;
	addr_t addr;
	word_t data_in;
	logic rd;
	logic wr;
	word_t data_out;
	logic done;
	logic stall;
	logic cache_hit;
	logic err;

	logic [31:0] lfsr;

	// Flat memory plus the tag store the cache is expected to hold
	word_t ref_mem [MEM_WORDS];
	logic m_valid [2][LINES];
	logic m_dirty [2][LINES];
	tag_t m_tag [2][LINES];
	logic m_victim;

	mem_system DUT (
		.clk(clk), .rst_n(rst_n), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
		.data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit), .err(err)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(NUM_REQUESTS * CYCLES_PER_REQUEST * CLK_PERIOD + 50 * CLK_PERIOD);
		$display("Timeout: the test sequence did not finish in the expected time");
		$display("Result: FAILED");
		$fatal(1, "watchdog expired");
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s (got %0h, expected %0h)", $time, what, actual,
				expected);
			$display("Result: FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// Expected outcome of one access, updating the model state
	task automatic model_access(input logic is_wr, input addr_t a, input word_t d,
			output word_t exp_data, output int exp_cycles, output logic exp_hit,
			output logic exp_err);
		tag_t t;
		index_t idx;
		logic hit0;
		logic hit1;
		int way;
		t = a[15:8];
		idx = a[7:3];
		exp_err = a[0];
		exp_hit = 1'b0;
		exp_cycles = 1;
		if (!a[0]) begin
			hit0 = m_valid[0][idx] && (m_tag[0][idx] == t);
			hit1 = m_valid[1][idx] && (m_tag[1][idx] == t);
			m_victim = ~m_victim;                       // Flips on every compare
			exp_hit = hit0 | hit1;
			if (exp_hit) begin
				way = hit1 ? 1 : 0;
			end else begin
				if (!m_valid[0][idx]) way = 0;
				else if (!m_valid[1][idx]) way = 1;
				else way = m_victim ? 1 : 0;
				exp_cycles = (m_valid[way][idx] && m_dirty[way][idx]) ? 13 : 9;
				m_valid[way][idx] = 1'b1;
				m_tag[way][idx] = t;
				m_dirty[way][idx] = 1'b0;
			end
			if (is_wr) begin
				m_dirty[way][idx] = 1'b1;
				ref_mem[a[15:1]] = d;
			end
		end
		exp_data = ref_mem[a[15:1]];
	endtask

	// Issue one request and wait for done, optionally toggling inputs while stalled
	task automatic run_request(input logic is_wr, input addr_t a, input word_t d,
			input logic scribble, output word_t rdata, output int cycles,
			output logic hit_flag, output logic err_flag);
		logic [31:0] junk;
		logic got_done;
		@(negedge clk);
		check_value(stall, 1'b0, "stall low before a new request");
		addr = a;
		data_in = d;
		rd = ~is_wr;
		wr = is_wr;
		cycles = 0;
		got_done = 1'b0;
		while (!got_done) begin
			@(negedge clk);
			cycles++;
			if (done) begin
				got_done = 1'b1;
			end else if (cycles >= WAIT_LIMIT) begin
				$display("No done for the request at address %h within %0d cycles", a,
					WAIT_LIMIT);
				$display("Result: FAILED");
				$fatal(1, "request timeout");
			end else begin
				check_value(stall, 1'b1, "stall held while the request is pending");
				if (scribble) begin
					take_bits(32, junk);
					addr = junk[15:0];
					data_in = junk[31:16];
					take_bits(2, junk);
					rd = junk[0];
					wr = junk[1];
				end else begin
					rd = 1'b0;
					wr = 1'b0;
				end
			end
		end
		check_value(stall, 1'b0, "stall low in the done cycle");
		rdata = data_out;
		hit_flag = cache_hit;
		err_flag = err;
		rd = 1'b0;
		wr = 1'b0;
	endtask

	task automatic access_check(input logic is_wr, input addr_t a, input word_t d,
			input logic scribble, output int cycles, output logic hit_flag);
		word_t got_data;
		word_t exp_data;
		int exp_cycles;
		logic exp_hit;
		logic exp_err;
		logic got_err;
		model_access(is_wr, a, d, exp_data, exp_cycles, exp_hit, exp_err);
		run_request(is_wr, a, d, scribble, got_data, cycles, hit_flag, got_err);
		check_value(cycles, exp_cycles, $sformatf("latency of access to %h", a));
		check_value(hit_flag, exp_hit, $sformatf("cache_hit of access to %h", a));
		check_value(got_err, exp_err, $sformatf("err of access to %h", a));
		if (!is_wr && !exp_err) begin
			check_value(got_data, exp_data, $sformatf("read data at %h", a));
		end
	endtask

`include "mem_system_tests.svh"

	initial begin
		rst_n = 1'b0;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		lfsr = 32'h48cf;
		m_victim = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = '0;
		end
		for (int w = 0; w < 2; w++) begin
			for (int l = 0; l < LINES; l++) begin
				m_valid[w][l] = 1'b0;
				m_dirty[w][l] = 1'b0;
				m_tag[w][l] = '0;
			end
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_cold_read();
		test_line_write();
		test_conflict();
		test_random_traffic();
		test_misaligned();
		test_stall_ignored();

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+bench
source/mem_system_pkg.sv
source/cache_way.sv
source/cache_controller.sv
source/banked_memory.sv
source/mem_system.sv
bench/mem_system_tb.sv
